// ==== Makefile ====
# Verilator build and run of the CPU core testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT ?= SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run $(TOP)"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/clock_gen.sv ====
`timescale 1ns/10ps

module clock_gen #(
    parameter int HALF_PERIOD_NS = 10,      // 20 ns clock
    parameter int RESET_CYCLES   = 5
) (
    input  logic reset_req_i,               // Start a fresh reset pulse
    output logic clk_o,
    output logic rst_o
);
    int rst_left = RESET_CYCLES;

    initial begin
        clk_o = 1'b0;
        rst_o = 1'b1;                       // In reset from time zero
        forever begin
            #(HALF_PERIOD_NS) clk_o = ~clk_o;
        end
    end

    // Reset moves 2 ns after the edge
    always @(posedge clk_o) begin
        if (reset_req_i) begin
            rst_left = RESET_CYCLES;
        end else if (rst_left > 0) begin
            rst_left = rst_left - 1;
        end
        #2;
        rst_o = (rst_left > 0);
    end

endmodule

// ==== bench/tb_cpu.sv ====
`timescale 1ns/10ps
`include "cpu_consts.svh"

module tb_cpu;
    import cpu_pkg::*;

    // ------------------------------
    // Run limits
    // ------------------------------
    localparam int TEST_COUNT        = 5;
    localparam int MAX_INSTR         = 100;
    localparam int CYCLES_PER_INSTR  = 40;      // Slow fetch plus decode and execute
    localparam int TEST_CYCLE_LIMIT  = MAX_INSTR * CYCLES_PER_INSTR;
    localparam int RUN_CYCLE_LIMIT   = TEST_COUNT * TEST_CYCLE_LIMIT;
    localparam int IDLE_CHECK_CYCLES = 50;

    logic    clk;
    logic    rst;
    logic    reset_req;
    logic    random_wait;
    wb_bus_t wb;
    word_t   wb_dat;
    logic    wb_ack;
    word_t   out;
    logic    out_stb;
    logic    ready;
    logic    halted;

    word_t   prog_q[$];                         // Program words from start address
    word_t   expected_q[$];                     // Values expected on out_o
    int      cycle_count = 0;

    clock_gen i_clock_gen (
        .reset_req_i   (reset_req),
        .clk_o         (clk),
        .rst_o         (rst)
    );

    wb_memory i_wb_memory (
        .clk_i         (clk),
        .wb_i          (wb),
        .random_wait_i (random_wait),
        .dat_o         (wb_dat),
        .ack_o         (wb_ack)
    );

    cpu_top i_cpu_top (
        .clk_i         (clk),
        .resetComplete (rst),
        .wb_o          (wb),
        .wb_dat_i      (wb_dat),
        .wb_ack_i      (wb_ack),
        .out_o         (out),
        .out_stb_o     (out_stb),
        .ready_o       (ready),
        .halted_o      (halted)
    );

    // Watchdog over the whole run
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= RUN_CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d cycles", RUN_CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $fatal(1, "watchdog");
        end
    end

    // ------------------------------
    // Instruction encoding
    // ------------------------------
    function automatic word_t ldi_instr(input int rd, input int imm);
        return {`OP_LDI, 1'b0, 3'(rd), 8'(imm)};    // Dest in 10:8
    endfunction

    function automatic word_t alu_instr(input opcode_t op, input logic ign,
                                        input int dest, input int src1, input int src2);
        return {op, 1'b0, ign, 1'b0, 3'(dest), 3'(src2), 3'(src1)};
    endfunction

    function automatic word_t otr_instr(input int src1);
        return {`OP_OTR, 9'd0, 3'(src1)};
    endfunction

    function automatic word_t jmp_instr(input int src1);
        return {`OP_JMP, 9'd0, 3'(src1)};
    endfunction

    // Offset counts from the word after the BNE
    function automatic word_t bne_instr(input int from, input int to);
        int offset;
        offset = to - (from + 1);
        return {`OP_BNE, 4'd0, 8'(offset)};
    endfunction

    function automatic word_t hlt_instr();
        return {`OP_HLT, 12'd0};
    endfunction

    // ------------------------------
    // Run control
    // ------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic load_program(input int start);
        for (int a = 0; a < 256; a++) begin
            i_wb_memory.mem[a] = word_t'(a);          // NOP with the address in its low byte
        end
        i_wb_memory.mem[`CPU_RESET_VECTOR] = {8'hA5, addr_t'(start)};  // High byte ignored
        foreach (prog_q[i]) begin
            i_wb_memory.mem[addr_t'(start + i)] = prog_q[i];
        end
    endtask

    // Collect every strobed output from reset to halt and compare
    task automatic run_program(input string name, input logic waits);
        word_t seen[$];
        int    cycles;
        @(posedge clk);
        #2;
        random_wait = waits;
        reset_req   = 1'b1;
        @(posedge clk);
        #2;
        reset_req = 1'b0;
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        assert (!ready && !halted && !out_stb && !wb.cyc && !wb.stb) else
            abort_run($sformatf("%s: outputs not inactive after reset", name));

        cycles = 0;
        while (!halted && cycles < TEST_CYCLE_LIMIT) begin
            @(negedge clk);
            cycles = cycles + 1;
            if (out_stb) begin
                assert (ready) else
                    abort_run($sformatf("Mismatch at %0t: ready_o got %b expected 1",
                                        $time, ready));
                seen.push_back(out);
            end
        end

        assert (halted) else
            abort_run($sformatf("%s: CPU did not halt within %0d cycles",
                                name, TEST_CYCLE_LIMIT));
        assert (!ready) else
            abort_run($sformatf("Mismatch at %0t: ready_o got %b expected 0",
                                $time, ready));
        assert (seen.size() == expected_q.size()) else
            abort_run($sformatf("Mismatch at %0t: out_o count got %0d expected %0d",
                                $time, seen.size(), expected_q.size()));
        foreach (expected_q[i]) begin
            assert (seen[i] == expected_q[i]) else
                abort_run($sformatf("Mismatch at %0t: out_o[%0d] got 0x%04h expected 0x%04h",
                                    $time, i, seen[i], expected_q[i]));
        end
        $display("%s: %0d outputs checked", name, seen.size());
    endtask

    // Countdown loop from 3 and then a CMP that must leave r1 alone
    task automatic build_countdown(input int start);
        int count;
        prog_q.delete();
        expected_q.delete();
        prog_q.push_back(ldi_instr(1, 3));
        prog_q.push_back(ldi_instr(2, 1));
        prog_q.push_back(alu_instr(`OP_SUB, 1'b0, 1, 1, 2));  // Loop head
        prog_q.push_back(otr_instr(1));
        prog_q.push_back(bne_instr(start + 4, start + 2));
        prog_q.push_back(alu_instr(`OP_SUB, 1'b1, 1, 1, 2));  // CMP
        prog_q.push_back(otr_instr(1));
        prog_q.push_back(hlt_instr());
        count = 3;
        do begin
            count = count - 1;
            expected_q.push_back(word_t'(count));
        end while (count != 0);
        expected_q.push_back(word_t'(count));
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic reset_vector_test();
        prog_q.delete();
        expected_q.delete();
        prog_q.push_back(ldi_instr(1, 'h5A));
        prog_q.push_back(otr_instr(1));
        prog_q.push_back(hlt_instr());
        expected_q.push_back(16'h005A);
        load_program('h10);
        run_program("reset vector", 1'b0);
    endtask

    task automatic alu_ops_test();
        int a;
        int b;
        int sh_left;
        int sh_right;
        a        = 'h9C;
        b        = 'hE7;
        sh_left  = 'h0B;
        sh_right = 'h03;
        prog_q.delete();
        expected_q.delete();
        prog_q.push_back(ldi_instr(1, a));
        prog_q.push_back(ldi_instr(2, b));
        prog_q.push_back(ldi_instr(4, sh_left));
        prog_q.push_back(ldi_instr(5, sh_right));
        prog_q.push_back(alu_instr(`OP_ADD, 1'b0, 3, 1, 2));
        prog_q.push_back(otr_instr(3));
        prog_q.push_back(alu_instr(`OP_SUB, 1'b0, 3, 1, 2));  // Wraps below zero
        prog_q.push_back(otr_instr(3));
        prog_q.push_back(alu_instr(`OP_SHL, 1'b0, 3, 1, 4));  // Bits leave the top
        prog_q.push_back(otr_instr(3));
        prog_q.push_back(alu_instr(`OP_SHR, 1'b0, 3, 2, 5));
        prog_q.push_back(otr_instr(3));
        prog_q.push_back(hlt_instr());
        expected_q.push_back(word_t'(a + b));
        expected_q.push_back(word_t'(a - b));
        expected_q.push_back(word_t'(a << (sh_left % 16)));
        expected_q.push_back(word_t'(b >> (sh_right % 16)));
        load_program('h20);
        run_program("alu ops", 1'b0);
    endtask

    task automatic cmp_bne_test();
        build_countdown('h30);
        load_program('h30);
        run_program("cmp and bne", 1'b0);
    endtask

    task automatic jmp_test();
        int target;
        target = 'h40 + 4;
        prog_q.delete();
        expected_q.delete();
        prog_q.push_back(ldi_instr(1, 'h77));       // Marker that must not show
        prog_q.push_back(ldi_instr(2, target));
        prog_q.push_back(jmp_instr(2));
        prog_q.push_back(otr_instr(1));             // Skipped
        prog_q.push_back(ldi_instr(3, 'h3C));       // Jump lands here
        prog_q.push_back(otr_instr(3));
        prog_q.push_back(otr_instr(2));
        prog_q.push_back(hlt_instr());
        expected_q.push_back(16'h003C);
        expected_q.push_back(word_t'(target));
        load_program('h40);
        run_program("jmp", 1'b0);
    endtask

    task automatic wait_state_test();
        build_countdown('h50);
        load_program('h50);
        run_program("wait states", 1'b1);
        repeat (IDLE_CHECK_CYCLES) begin
            @(negedge clk);
            assert (!wb.cyc) else
                abort_run("A bus cycle started after the CPU halted");
            assert (halted) else
                abort_run("halted_o dropped without a reset");
        end
    endtask

    initial begin
        reset_req   = 1'b0;
        random_wait = 1'b0;
        reset_vector_test();
        alu_ops_test();
        cmp_bne_test();
        jmp_test();
        wait_state_test();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== bench/wb_memory.sv ====
`timescale 1ns/10ps

module wb_memory (
    input  logic             clk_i,
    input  cpu_pkg::wb_bus_t wb_i,
    input  logic             random_wait_i,    // 0 to 3 wait cycles per access
    output cpu_pkg::word_t   dat_o,
    output logic             ack_o
);
    import cpu_pkg::*;

    word_t       mem [256];                     // Filled by the testbench
    integer      seed      = 95784;
    logic [31:0] draw;
    int          wait_left = 0;
    logic        busy      = 1'b0;              // Request seen, ack pending
    logic        ack_next;
    word_t       dat_next;

    initial begin
        ack_o = 1'b0;
        dat_o = '0;
    end

    // ------------------------------
    // Registered ack, one per request
    // ------------------------------
    always @(posedge clk_i) begin
        ack_next = 1'b0;
        if (wb_i.cyc && wb_i.stb && !ack_o) begin
            if (!busy) begin
                busy      = 1'b1;
                draw      = $random(seed);
                wait_left = random_wait_i ? int'(draw[1:0]) : 0;
            end
            if (wait_left == 0) begin
                ack_next = 1'b1;
                busy     = 1'b0;
            end else begin
                wait_left = wait_left - 1;      // Still holding off
            end
        end else if (!wb_i.cyc) begin
            busy = 1'b0;                        // Master dropped the cycle
        end
        dat_next = mem[wb_i.adr[7:0]];          // 256 words, low address bits
        #2;
        ack_o = ack_next;
        dat_o = dat_next;
    end

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/10ps
`include "cpu_consts.svh"

module alu (
    input  logic                clk_i,
    input  logic                resetComplete,
    input  cpu_pkg::ctrl_t      ctrl_i,
    input  cpu_pkg::word_t      a_i,
    input  cpu_pkg::word_t      b_i,
    output cpu_pkg::word_t      result_o,
    output cpu_pkg::alu_flags_t flags_o
);
    import cpu_pkg::*;

    localparam int W       = `CPU_DATA_WIDTH;
    localparam int SHAMT_W = $clog2(W);     // Low 4 bits of b

    logic [SHAMT_W-1:0] shamt;
    logic [W:0]         wide;               // Result plus carry bit
    word_t              res;
    logic               carry;
    logic               ovf;
    alu_flags_t         flags_next;

    assign shamt = b_i[SHAMT_W-1:0];

    // ------------------------------
    // Operations
    // ------------------------------
    always_comb begin
        wide  = '0;
        res   = '0;
        carry = 1'b0;
        ovf   = 1'b0;
        case (ctrl_i.alu_op)
            `OP_ADD: begin
                wide  = {1'b0, a_i} + {1'b0, b_i};
                res   = wide[W-1:0];
                carry = wide[W];
                ovf   = (a_i[W-1] == b_i[W-1]) && (wide[W-1] != a_i[W-1]);
            end
            `OP_SUB: begin
                wide  = {1'b0, a_i} - {1'b0, b_i};
                res   = wide[W-1:0];
                carry = wide[W];                // Borrow
                ovf   = (a_i[W-1] != b_i[W-1]) && (wide[W-1] != a_i[W-1]);
            end
            `OP_SHL: begin
                wide  = {1'b0, a_i} << shamt;
                res   = wide[W-1:0];
                carry = wide[W];                // Last bit out the top
            end
            `OP_SHR: begin
                wide  = {a_i, 1'b0} >> shamt;
                res   = wide[W:1];
                carry = wide[0];                // Last bit out the bottom
            end
            default: begin
                res = '0;
            end
        endcase
    end

    assign flags_next.z = (res == '0);
    assign flags_next.n = res[W-1];
    assign flags_next.c = carry;
    assign flags_next.v = ovf;

    // ------------------------------
    // Result and flag registers
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (resetComplete || ctrl_i.flg_rst) begin
            flags_o <= '0;                      // Clear after a taken BNE
        end else if (ctrl_i.flg_ld) begin
            flags_o <= flags_next;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ctrl_i.alu_ld) begin
            result_o <= res;
        end
    end

endmodule

// ==== logic/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// ------------------------------
// Datapath widths
// ------------------------------
`define CPU_DATA_WIDTH   16
`define CPU_ADDR_WIDTH   8      // Instruction space, 256 words
`define CPU_REG_COUNT    8
`define CPU_WB_ADR_WIDTH 10     // Wishbone word address, PC zero-extended

// Word at this address holds the start address in its low byte
`define CPU_RESET_VECTOR 8'h00

// ------------------------------
// Opcodes, IR bits 15:12
// ------------------------------
// ALU ops reuse the opcode value
`define OP_NOP 4'd0
`define OP_ADD 4'd1
`define OP_SUB 4'd2    // CMP when ignore_dest is set
`define OP_SHL 4'd3
`define OP_SHR 4'd4
`define OP_BNE 4'd5    // Signed 8 bit offset from incremented PC
`define OP_JMP 4'd6
`define OP_LDI 4'd7    // Dest in bits 10:8
`define OP_OTR 4'd8
`define OP_HLT 4'd9

`endif

// ==== logic/cpu_pkg.sv ====
`include "cpu_consts.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_WIDTH-1:0]        word_t;
    typedef logic [`CPU_ADDR_WIDTH-1:0]        addr_t;
    typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_idx_t;
    typedef logic [3:0]                        opcode_t;
    typedef logic [`CPU_WB_ADR_WIDTH-1:0]      wb_adr_t;

    // Instruction word layout
    typedef struct packed {
        opcode_t  opcode;       // 15:12
        logic     spare_hi;     // 11
        logic     ignore_dest;  // 10, flags only
        logic     spare_lo;     // 9
        reg_idx_t dest;         // 8:6
        reg_idx_t src2;         // 5:3
        reg_idx_t src1;         // 2:0
    } instr_t;

    // Z sits at bit 0
    typedef struct packed {
        logic v;    // Signed overflow
        logic n;    // Sign of result
        logic c;    // Carry, borrow or last bit shifted out
        logic z;    // Result zero
    } alu_flags_t;

    typedef enum logic [1:0] {
        PC_SRC_VECTOR,
        PC_SRC_IMM_LOW,
        PC_SRC_BRANCH,
        PC_SRC_REG_SRC1
    } pc_src_e;

    typedef enum logic {
        DATA_SRC_IMM,
        DATA_SRC_ALU
    } data_src_e;

    typedef enum logic [3:0] {
        S_RESET,
        S_FETCH,
        S_DECODE,
        S_EXECUTE,
        S_BASIC_EXECUTE,
        S_READY,
        S_HALT
    } seq_state_e;

    typedef enum logic [1:0] {
        V_VECTOR1,      // Load vector into PC
        V_VECTOR2,      // Fetch vector word
        V_VECTOR3       // Start address into PC
    } vector_state_e;

    // Datapath strobes, all active high
    typedef struct packed {
        logic      pc_ld;
        logic      pc_inc;
        pc_src_e   pc_src;
        logic      fetch_req;
        logic      reg_we;
        data_src_e data_src;
        logic      alu_ld;
        logic      flg_ld;
        logic      flg_rst;
        opcode_t   alu_op;
        logic      out_ld;
    } ctrl_t;

    // Master side Wishbone request
    typedef struct packed {
        logic    cyc;
        logic    stb;
        wb_adr_t adr;
    } wb_bus_t;

endpackage

// ==== logic/cpu_top.sv ====
`timescale 1ns/10ps

module cpu_top (
    input  logic             clk_i,
    input  logic             resetComplete,
    output cpu_pkg::wb_bus_t wb_o,          // Instruction fetch master
    input  cpu_pkg::word_t   wb_dat_i,
    input  logic             wb_ack_i,
    output cpu_pkg::word_t   out_o,
    output logic             out_stb_o,
    output logic             ready_o,
    output logic             halted_o
);
    import cpu_pkg::*;

    ctrl_t      ctrl;           // Strobes from the sequencer
    instr_t     ir;
    logic       fetch_done;
    alu_flags_t flags;
    addr_t      pc;
    word_t      src1;
    word_t      src2;
    word_t      alu_result;

    // ------------------------------
    // Control
    // ------------------------------
    seq_control i_seq_control (
        .clk_i         (clk_i),
        .resetComplete (resetComplete),
        .ir_i          (ir),
        .fetch_done_i  (fetch_done),
        .flags_i       (flags),
        .ctrl_o        (ctrl),
        .ready_o       (ready_o),
        .halted_o      (halted_o)
    );

    fetch_unit i_fetch_unit (
        .clk_i         (clk_i),
        .resetComplete (resetComplete),
        .ctrl_i        (ctrl),
        .pc_i          (pc),
        .wb_o          (wb_o),
        .wb_dat_i      (wb_dat_i),
        .wb_ack_i      (wb_ack_i),
        .ir_o          (ir),
        .fetch_done_o  (fetch_done)
    );

    // ------------------------------
    // Datapath
    // ------------------------------
    program_counter i_program_counter (
        .clk_i         (clk_i),
        .resetComplete (resetComplete),
        .ctrl_i        (ctrl),
        .ir_i          (ir),
        .reg_src1_i    (src1),          // JMP target
        .pc_o          (pc)
    );

    register_bank i_register_bank (
        .clk_i         (clk_i),
        .resetComplete (resetComplete),
        .ctrl_i        (ctrl),
        .ir_i          (ir),
        .alu_result_i  (alu_result),
        .src1_o        (src1),
        .src2_o        (src2),
        .out_o         (out_o),
        .out_stb_o     (out_stb_o)
    );

    alu i_alu (
        .clk_i         (clk_i),
        .resetComplete (resetComplete),
        .ctrl_i        (ctrl),
        .a_i           (src1),
        .b_i           (src2),
        .result_o      (alu_result),
        .flags_o       (flags)
    );

endmodule

// ==== logic/fetch_unit.sv ====
`timescale 1ns/10ps

module fetch_unit (
    input  logic             clk_i,
    input  logic             resetComplete,
    input  cpu_pkg::ctrl_t   ctrl_i,
    input  cpu_pkg::addr_t   pc_i,
    output cpu_pkg::wb_bus_t wb_o,
    input  cpu_pkg::word_t   wb_dat_i,
    input  logic             wb_ack_i,
    output cpu_pkg::instr_t  ir_o,
    output logic             fetch_done_o
);
    import cpu_pkg::*;

    // Ack only counts inside an open cycle
    assign fetch_done_o = wb_o.cyc && wb_ack_i;

    // ------------------------------
    // Wishbone classic read master
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (resetComplete) begin
            wb_o.cyc <= 1'b0;
            wb_o.stb <= 1'b0;
        end else if (wb_o.cyc) begin
            if (wb_ack_i) begin
                wb_o.cyc <= 1'b0;           // Drop right after the ack edge
                wb_o.stb <= 1'b0;
            end
        end else if (ctrl_i.fetch_req) begin
            wb_o.cyc <= 1'b1;               // cyc, stb and adr together
            wb_o.stb <= 1'b1;
            wb_o.adr <= wb_adr_t'(pc_i);    // Held until ack
        end
    end

    // Instruction register
    always_ff @(posedge clk_i) begin
        if (fetch_done_o) begin
            ir_o <= instr_t'(wb_dat_i);
        end
    end

endmodule

// ==== logic/program_counter.sv ====
`timescale 1ns/10ps
`include "cpu_consts.svh"

module program_counter (
    input  logic            clk_i,
    input  logic            resetComplete,
    input  cpu_pkg::ctrl_t  ctrl_i,
    input  cpu_pkg::instr_t ir_i,
    input  cpu_pkg::word_t  reg_src1_i,
    output cpu_pkg::addr_t  pc_o
);
    import cpu_pkg::*;

    addr_t branch_target;
    addr_t pc_next;

    // PC already points past the BNE, so backward offsets are one larger
    assign branch_target = pc_o + addr_t'(signed'(ir_i[7:0]));

    // ------------------------------
    // Load source mux
    // ------------------------------
    always_comb begin
        case (ctrl_i.pc_src)
            PC_SRC_VECTOR:   pc_next = `CPU_RESET_VECTOR;
            PC_SRC_IMM_LOW:  pc_next = addr_t'(ir_i[7:0]);     // Start address
            PC_SRC_BRANCH:   pc_next = branch_target;
            PC_SRC_REG_SRC1: pc_next = addr_t'(reg_src1_i);    // JMP, low byte
            default:         pc_next = pc_o;
        endcase
    end

    // Load wins over increment
    always_ff @(posedge clk_i) begin
        if (resetComplete) begin
            pc_o <= `CPU_RESET_VECTOR;
        end else if (ctrl_i.pc_ld) begin
            pc_o <= pc_next;
        end else if (ctrl_i.pc_inc) begin
            pc_o <= pc_o + 1'b1;
        end
    end

endmodule

// ==== logic/register_bank.sv ====
`timescale 1ns/10ps

module register_bank (
    input  logic            clk_i,
    input  logic            resetComplete,
    input  cpu_pkg::ctrl_t  ctrl_i,
    input  cpu_pkg::instr_t ir_i,
    input  cpu_pkg::word_t  alu_result_i,
    output cpu_pkg::word_t  src1_o,
    output cpu_pkg::word_t  src2_o,
    output cpu_pkg::word_t  out_o,
    output logic            out_stb_o
);
    import cpu_pkg::*;

    localparam int REG_COUNT = 2 ** $bits(reg_idx_t);

    word_t    regs [REG_COUNT];
    reg_idx_t wr_idx;
    word_t    wr_data;

    // ------------------------------
    // Write port
    // ------------------------------
    always_comb begin
        if (ctrl_i.data_src == DATA_SRC_IMM) begin
            wr_idx  = reg_idx_t'(ir_i[10:8]);   // LDI dest sits higher up
            wr_data = word_t'(ir_i[7:0]);       // Zero-extended
        end else begin
            wr_idx  = ir_i.dest;
            wr_data = alu_result_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (resetComplete) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl_i.reg_we) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Two async read ports
    assign src1_o = regs[ir_i.src1];
    assign src2_o = regs[ir_i.src2];

    // ------------------------------
    // Output port
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (resetComplete) begin
            out_stb_o <= 1'b0;
        end else begin
            out_stb_o <= ctrl_i.out_ld;         // One cycle, alongside new value
        end
    end

    always_ff @(posedge clk_i) begin
        if (ctrl_i.out_ld) begin
            out_o <= src1_o;
        end
    end

endmodule

// ==== logic/seq_control.sv ====
`timescale 1ns/10ps
`include "cpu_consts.svh"

module seq_control (
    input  logic                clk_i,
    input  logic                resetComplete,
    input  cpu_pkg::instr_t     ir_i,
    input  logic                fetch_done_i,   // IR loads at end of this cycle
    input  cpu_pkg::alu_flags_t flags_i,
    output cpu_pkg::ctrl_t      ctrl_o,
    output logic                ready_o,
    output logic                halted_o
);
    import cpu_pkg::*;

    seq_state_e    state;
    seq_state_e    next_state;
    vector_state_e vector_state;
    vector_state_e next_vector_state;
    logic          alu_instr;       // Opcode runs through the ALU

    // ------------------------------
    // State registers
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (resetComplete) begin
            state        <= S_RESET;
            vector_state <= V_VECTOR1;
        end else begin
            state        <= next_state;
            vector_state <= next_vector_state;
        end
    end

    // ------------------------------
    // Strobes and next state
    // ------------------------------
    always_comb begin
        // Everything idle unless a state asks
        ctrl_o            = '0;
        ctrl_o.pc_src     = PC_SRC_VECTOR;
        ctrl_o.data_src   = DATA_SRC_IMM;
        ctrl_o.alu_op     = `OP_NOP;
        next_state        = state;
        next_vector_state = vector_state;
        alu_instr         = 1'b0;

        case (state)
            S_RESET: begin
                case (vector_state)
                    V_VECTOR1: begin
                        ctrl_o.pc_ld      = 1'b1;       // PC <= reset vector
                        ctrl_o.pc_src     = PC_SRC_VECTOR;
                        next_vector_state = V_VECTOR2;
                    end
                    V_VECTOR2: begin
                        ctrl_o.fetch_req = 1'b1;        // Vector word into IR
                        if (fetch_done_i) begin
                            next_vector_state = V_VECTOR3;
                        end
                    end
                    V_VECTOR3: begin
                        // Low byte of the vector word is the start address
                        ctrl_o.pc_ld      = 1'b1;
                        ctrl_o.pc_src     = PC_SRC_IMM_LOW;
                        next_vector_state = V_VECTOR1;
                        next_state        = S_READY;
                    end
                    default: begin
                        next_vector_state = V_VECTOR1;
                    end
                endcase
            end

            S_READY: begin
                next_state = S_FETCH;           // ready_o first high here
            end

            S_FETCH: begin
                ctrl_o.fetch_req = 1'b1;
                if (fetch_done_i) begin
                    ctrl_o.pc_inc = 1'b1;       // Step past this instruction
                    next_state    = S_DECODE;
                end
            end

            S_DECODE: begin
                next_state = S_FETCH;           // Most opcodes finish here
                case (ir_i.opcode)
                    `OP_ADD, `OP_SUB, `OP_SHL, `OP_SHR: begin
                        alu_instr = 1'b1;
                    end
                    `OP_BNE: begin
                        if (!flags_i.z) begin
                            ctrl_o.pc_ld   = 1'b1;
                            ctrl_o.pc_src  = PC_SRC_BRANCH;
                            ctrl_o.flg_rst = 1'b1;  // Flags spent on the test
                            next_state     = S_BASIC_EXECUTE;
                        end
                    end
                    `OP_JMP: begin
                        ctrl_o.pc_ld  = 1'b1;
                        ctrl_o.pc_src = PC_SRC_REG_SRC1;
                        next_state    = S_BASIC_EXECUTE;
                    end
                    `OP_LDI: begin
                        ctrl_o.reg_we   = 1'b1;     // Zero-extended low byte
                        ctrl_o.data_src = DATA_SRC_IMM;
                    end
                    `OP_OTR: begin
                        ctrl_o.out_ld = 1'b1;
                    end
                    `OP_HLT: begin
                        next_state = S_HALT;
                    end
                    default: begin
                        // NOP and unknown opcodes go straight to the next fetch
                    end
                endcase

                if (alu_instr) begin
                    ctrl_o.alu_op = ir_i.opcode;    // Opcode doubles as ALU op
                    ctrl_o.flg_ld = 1'b1;           // Flags always kept
                    if (!ir_i.ignore_dest) begin
                        ctrl_o.alu_ld = 1'b1;       // Result reg, written back next
                        next_state    = S_EXECUTE;
                    end
                end
            end

            S_EXECUTE: begin
                ctrl_o.reg_we   = 1'b1;
                ctrl_o.data_src = DATA_SRC_ALU;
                next_state      = S_FETCH;
            end

            S_BASIC_EXECUTE: begin
                next_state = S_FETCH;           // Lets the new PC settle
            end

            S_HALT: begin
                next_state = S_HALT;            // Only reset leaves
            end

            default: begin
                next_state = S_RESET;
            end
        endcase
    end

    assign ready_o  = (state != S_RESET) && (state != S_HALT);
    assign halted_o = (state == S_HALT);

endmodule

// ==== tb.f ====
+incdir+logic
logic/cpu_pkg.sv
logic/fetch_unit.sv
logic/program_counter.sv
logic/register_bank.sv
logic/alu.sv
logic/seq_control.sv
logic/cpu_top.sv
bench/clock_gen.sv
bench/wb_memory.sv
bench/tb_cpu.sv
